// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

	// ====================================================================
	// Widths and sizes.
	// ====================================================================
	localparam int xlen       = 32;
	localparam int reg_addr_w = 4;
	localparam int reg_count  = 1 << reg_addr_w;
	localparam int dmem_words = 64;

	// Opcode groups, one bit each in op_group_t.
	localparam int inst_count = 10;
	localparam int inst_lui   = 0;
	localparam int inst_auipc = 1;
	localparam int inst_jal   = 2;
	localparam int inst_jalr  = 3;
	localparam int inst_beq   = 4;
	localparam int inst_lw    = 5;
	localparam int inst_sw    = 6;
	localparam int inst_addi  = 7;
	localparam int inst_add   = 8;
	localparam int inst_csr   = 9;

	// Instruction formats.
	localparam int fmt_count = 6;
	localparam int fmt_r     = 0;
	localparam int fmt_i     = 1;
	localparam int fmt_s     = 2;
	localparam int fmt_b     = 3;
	localparam int fmt_u     = 4;
	localparam int fmt_j     = 5;

	typedef logic [inst_count-1:0] op_group_t;

	// ====================================================================
	// Stage payloads.
	// ====================================================================
	typedef struct packed {
		logic [xlen-1:0]       pc;
		op_group_t             op_group;
		logic [2:0]            funct3;
		logic                  funct7_5;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic [xlen-1:0]       src1;
		logic [xlen-1:0]       src2;
		logic [xlen-1:0]       imm;
	} dec_t;

	typedef struct packed {
		logic [xlen-1:0]       pc;
		op_group_t             op_group;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic [xlen-1:0]       result;
		logic [xlen-1:0]       store_data;
	} exm_t;

	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic [xlen-1:0]       data;
	} ret_t;

	// Busy means the stage holds a valid item.
	typedef struct packed {
		logic                  busy;
		logic [reg_addr_w-1:0] rd;
		logic                  reg_wen;
		logic                  load_pending;
		logic [xlen-1:0]       value;
	} fwd_t;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [rv_core_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_core_pkg::reg_addr_w-1:0] rs2,
	output logic [rv_core_pkg::xlen-1:0]       rdata1,
	output logic [rv_core_pkg::xlen-1:0]       rdata2,
	input  logic                              wen,
	input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
	input  logic [rv_core_pkg::xlen-1:0]       wdata
);

	logic [rv_core_pkg::xlen-1:0] regs [rv_core_pkg::reg_count];
	logic                         write_live;

	// x0 is never written, so it reads as zero.
	assign write_live = wen && (waddr != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rv_core_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_live) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write shows up on the read ports.
	assign rdata1 = (write_live && (waddr == rs1)) ? wdata : regs[rs1];
	assign rdata2 = (write_live && (waddr == rs2)) ? wdata : regs[rs2];

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [31:0]                       inst,
	input  logic [31:0]                       pc,
	input  logic                              in_valid,
	output logic                              in_ready,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
	input  logic [rv_core_pkg::xlen-1:0]       rdata1,
	input  logic [rv_core_pkg::xlen-1:0]       rdata2,
	input  rv_core_pkg::fwd_t                 fwd_ex,
	input  rv_core_pkg::fwd_t                 fwd_exm,
	input  rv_core_pkg::fwd_t                 fwd_mem,
	output logic                              out_valid,
	output rv_core_pkg::dec_t                 out,
	input  logic                              out_ready
);

	logic [6:0]                          opcode;
	rv_core_pkg::op_group_t              op_group;
	logic [rv_core_pkg::fmt_count-1:0]   fmt;
	logic [31:0]                         imm;
	logic                                reg_wen;
	logic                                need_rs1;
	logic                                need_rs2;
	rv_core_pkg::fwd_t                   sel1;
	rv_core_pkg::fwd_t                   sel2;
	logic                                load_use_hazard;
	logic                                slot_free;
	logic                                in_fire;
	logic                                out_fire;

	function automatic logic hits(rv_core_pkg::fwd_t f, logic [rv_core_pkg::reg_addr_w-1:0] r);
		return f.busy && f.reg_wen && (f.rd != '0) && (f.rd == r);
	endfunction

	// Youngest producer wins. The register file is the fallback.
	function automatic rv_core_pkg::fwd_t pick(
		input logic [rv_core_pkg::reg_addr_w-1:0] r,
		input logic [rv_core_pkg::xlen-1:0]       rf_value,
		input rv_core_pkg::fwd_t                 ex,
		input rv_core_pkg::fwd_t                 exm,
		input rv_core_pkg::fwd_t                 mem
	);
		rv_core_pkg::fwd_t sel;
		sel = '0;
		sel.value = rf_value;
		if (hits(ex, r)) begin
			sel = ex;
		end else if (hits(exm, r)) begin
			sel = exm;
		end else if (hits(mem, r)) begin
			sel = mem;
		end
		return sel;
	endfunction

	// ====================================================================
	// Instruction decode.
	// ====================================================================
	assign opcode = inst[6:0];
	assign rs1    = inst[15 +: rv_core_pkg::reg_addr_w];
	assign rs2    = inst[20 +: rv_core_pkg::reg_addr_w];

	assign op_group[rv_core_pkg::inst_lui]   = (opcode == 7'b0110111);
	assign op_group[rv_core_pkg::inst_auipc] = (opcode == 7'b0010111);
	assign op_group[rv_core_pkg::inst_jal]   = (opcode == 7'b1101111);
	assign op_group[rv_core_pkg::inst_jalr]  = (opcode == 7'b1100111);
	assign op_group[rv_core_pkg::inst_beq]   = (opcode == 7'b1100011);
	assign op_group[rv_core_pkg::inst_lw]    = (opcode == 7'b0000011);
	assign op_group[rv_core_pkg::inst_sw]    = (opcode == 7'b0100011);
	assign op_group[rv_core_pkg::inst_addi]  = (opcode == 7'b0010011);
	assign op_group[rv_core_pkg::inst_add]   = (opcode == 7'b0110011);
	assign op_group[rv_core_pkg::inst_csr]   = (opcode == 7'b1110011);

	assign fmt[rv_core_pkg::fmt_r] = op_group[rv_core_pkg::inst_add];
	assign fmt[rv_core_pkg::fmt_i] = op_group[rv_core_pkg::inst_jalr] | op_group[rv_core_pkg::inst_lw]
		| op_group[rv_core_pkg::inst_addi] | op_group[rv_core_pkg::inst_csr];
	assign fmt[rv_core_pkg::fmt_s] = op_group[rv_core_pkg::inst_sw];
	assign fmt[rv_core_pkg::fmt_b] = op_group[rv_core_pkg::inst_beq];
	assign fmt[rv_core_pkg::fmt_u] = op_group[rv_core_pkg::inst_lui] | op_group[rv_core_pkg::inst_auipc];
	assign fmt[rv_core_pkg::fmt_j] = op_group[rv_core_pkg::inst_jal];

	assign imm =
		fmt[rv_core_pkg::fmt_i] ? {{20{inst[31]}}, inst[31:20]} :
		fmt[rv_core_pkg::fmt_u] ? {inst[31:12], 12'b0} :
		fmt[rv_core_pkg::fmt_s] ? {{20{inst[31]}}, inst[31:25], inst[11:7]} :
		fmt[rv_core_pkg::fmt_j] ? {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} :
		fmt[rv_core_pkg::fmt_b] ? {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0} :
		32'b0;

	// CSR ops retire without a register write.
	assign reg_wen = (fmt[rv_core_pkg::fmt_i] & ~op_group[rv_core_pkg::inst_csr])
		| fmt[rv_core_pkg::fmt_u] | fmt[rv_core_pkg::fmt_j] | fmt[rv_core_pkg::fmt_r];

	// ====================================================================
	// Operand forwarding and load-use stall.
	// ====================================================================
	assign need_rs2 = op_group[rv_core_pkg::inst_beq] | op_group[rv_core_pkg::inst_sw]
		| op_group[rv_core_pkg::inst_add];
	assign need_rs1 = need_rs2 | op_group[rv_core_pkg::inst_jalr] | op_group[rv_core_pkg::inst_lw]
		| op_group[rv_core_pkg::inst_addi] | op_group[rv_core_pkg::inst_csr];

	assign sel1 = pick(rs1, rdata1, fwd_ex, fwd_exm, fwd_mem);
	assign sel2 = pick(rs2, rdata2, fwd_ex, fwd_exm, fwd_mem);

	assign load_use_hazard = (need_rs1 & sel1.load_pending) | (need_rs2 & sel2.load_pending);

	// ====================================================================
	// Output register and handshake.
	// ====================================================================
	assign in_ready = ~load_use_hazard & (slot_free | out_ready);
	assign in_fire  = in_valid & in_ready;
	assign out_fire = out_valid & out_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_free <= 1'b1;
			out_valid <= 1'b0;
		end else begin
			slot_free <= ~in_fire & (slot_free | out_fire);
			out_valid <= in_fire | (out_valid & ~out_ready);
		end
	end

	always_ff @(posedge clock) begin
		if (in_fire) begin
			out.pc       <= pc;
			out.op_group <= op_group;
			out.funct3   <= inst[14:12];
			out.funct7_5 <= inst[30];
			out.rd       <= inst[7 +: rv_core_pkg::reg_addr_w];
			out.reg_wen  <= reg_wen;
			out.src1     <= sel1.value;
			out.src2     <= sel2.value;
			out.imm      <= imm;
		end
	end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
	input  rv_core_pkg::dec_t dec,
	input  logic              dec_valid,
	output logic              dec_ready,
	output rv_core_pkg::fwd_t fwd,
	output rv_core_pkg::exm_t out,
	output logic              out_valid,
	input  logic              out_ready
);

	logic [rv_core_pkg::xlen-1:0] result;
	logic [rv_core_pkg::xlen-1:0] base_imm;
	logic [rv_core_pkg::xlen-1:0] pc_imm;
	logic [rv_core_pkg::xlen-1:0] link;
	logic [rv_core_pkg::xlen-1:0] reg_reg;

	assign base_imm = dec.src1 + dec.imm;
	assign pc_imm   = dec.pc + dec.imm;
	assign link     = dec.pc + 32'd4;
	assign reg_reg  = dec.funct7_5 ? (dec.src1 - dec.src2) : (dec.src1 + dec.src2);

	// ====================================================================
	// ALU and address computation.
	// ====================================================================
	always_comb begin
		result = '0;
		if (dec.op_group[rv_core_pkg::inst_lui]) begin
			result = dec.imm;
		end else if (dec.op_group[rv_core_pkg::inst_auipc]) begin
			result = pc_imm;
		end else if (dec.op_group[rv_core_pkg::inst_jal] | dec.op_group[rv_core_pkg::inst_jalr]) begin
			result = link;
		end else if (dec.op_group[rv_core_pkg::inst_addi] | dec.op_group[rv_core_pkg::inst_lw]
			| dec.op_group[rv_core_pkg::inst_sw]) begin
			result = base_imm;
		end else if (dec.op_group[rv_core_pkg::inst_add] && (dec.funct3 == 3'b000)) begin
			// Only add and sub exist in the R group.
			result = reg_reg;
		end
	end

	assign out.pc         = dec.pc;
	assign out.op_group   = dec.op_group;
	assign out.rd         = dec.rd;
	assign out.reg_wen    = dec.reg_wen;
	assign out.result     = result;
	assign out.store_data = dec.src2;

	assign out_valid = dec_valid;
	assign dec_ready = out_ready;

	// A load here has no data yet.
	assign fwd.busy         = dec_valid;
	assign fwd.rd           = dec.rd;
	assign fwd.reg_wen      = dec.reg_wen;
	assign fwd.load_pending = dec.op_group[rv_core_pkg::inst_lw];
	assign fwd.value        = result;

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t din,
	output logic     out_valid,
	output payload_t dout,
	input  logic     out_ready
);

	logic in_fire;

	// Room when empty, or when the held item leaves this cycle.
	assign in_ready = ~out_valid | out_ready;
	assign in_fire  = in_valid & in_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_fire | (out_valid & ~out_ready);
		end
	end

	always_ff @(posedge clock) begin
		if (in_fire) begin
			dout <= din;
		end
	end

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
	input  logic              clock,
	input  logic              reset,
	input  logic              in_valid,
	output logic              in_ready,
	input  rv_core_pkg::exm_t din,
	output rv_core_pkg::fwd_t fwd_in,
	output rv_core_pkg::fwd_t fwd,
	output logic              out_valid,
	output rv_core_pkg::ret_t out,
	input  logic              out_ready
);

	localparam int idx_w = $clog2(rv_core_pkg::dmem_words);

	rv_core_pkg::exm_t            held;
	logic                         busy;
	logic                         waiting;
	logic                         in_fire;
	logic                         din_mem;
	logic                         held_lw;
	logic [idx_w-1:0]             held_idx;
	logic [rv_core_pkg::xlen-1:0] load_data;
	logic [rv_core_pkg::xlen-1:0] dmem [rv_core_pkg::dmem_words];

	assign din_mem  = din.op_group[rv_core_pkg::inst_lw] | din.op_group[rv_core_pkg::inst_sw];
	assign held_lw  = held.op_group[rv_core_pkg::inst_lw];
	assign held_idx = held.result[idx_w+1:2];

	assign out_valid = busy & ~waiting;
	assign in_ready  = ~busy | (out_valid & out_ready);
	assign in_fire   = in_valid & in_ready;

	// Loads and stores spend one wait cycle on the array.
	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			waiting <= 1'b0;
		end else if (in_fire) begin
			busy    <= 1'b1;
			waiting <= din_mem;
		end else begin
			if (out_valid & out_ready) begin
				busy <= 1'b0;
			end
			waiting <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_fire) begin
			held <= din;
		end
		if (busy & waiting) begin
			load_data <= dmem[held_idx];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rv_core_pkg::dmem_words; i++) begin
				dmem[i] <= '0;
			end
		end else if (busy & waiting & held.op_group[rv_core_pkg::inst_sw]) begin
			dmem[held_idx] <= held.store_data;
		end
	end

	assign out.pc      = held.pc;
	assign out.rd      = held.rd;
	assign out.reg_wen = held.reg_wen;
	assign out.data    = held_lw ? load_data : held.result;

	// ====================================================================
	// Forwarding for the waiting item and the held item.
	// ====================================================================
	assign fwd_in.busy         = in_valid;
	assign fwd_in.rd           = din.rd;
	assign fwd_in.reg_wen      = din.reg_wen;
	assign fwd_in.load_pending = din.op_group[rv_core_pkg::inst_lw];
	assign fwd_in.value        = din.result;

	assign fwd.busy         = busy;
	assign fwd.rd           = held.rd;
	assign fwd.reg_wen      = held.reg_wen;
	assign fwd.load_pending = held_lw & waiting;
	assign fwd.value        = out.data;

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
	input  logic              clock,
	input  logic              reset,
	input  logic              fetch_valid,
	input  logic [31:0]       fetch_inst,
	input  logic [31:0]       fetch_pc,
	output logic              fetch_ready,
	output logic              retire_valid,
	output rv_core_pkg::ret_t retire
);

	logic [rv_core_pkg::reg_addr_w-1:0] rs1;
	logic [rv_core_pkg::reg_addr_w-1:0] rs2;
	logic [rv_core_pkg::xlen-1:0]       rdata1;
	logic [rv_core_pkg::xlen-1:0]       rdata2;
	rv_core_pkg::fwd_t                  fwd_ex;
	rv_core_pkg::fwd_t                  fwd_exm;
	rv_core_pkg::fwd_t                  fwd_mem;
	rv_core_pkg::dec_t                  dec;
	logic                               dec_valid;
	logic                               dec_ready;
	rv_core_pkg::exm_t                  exe_out;
	logic                               exe_valid;
	logic                               exe_ready;
	rv_core_pkg::exm_t                  exm;
	logic                               exm_valid;
	logic                               exm_ready;
	rv_core_pkg::ret_t                  mem_out;
	logic                               mem_valid;
	logic                               mem_ready;

	// Retire writes the register file in the cycle it fires.
	reg_file i_reg_file (
		.clock(clock), .reset(reset),
		.rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.wen(retire_valid & retire.reg_wen), .waddr(retire.rd), .wdata(retire.data)
	);

	decode_stage i_decode_stage (
		.clock(clock), .reset(reset),
		.inst(fetch_inst), .pc(fetch_pc), .in_valid(fetch_valid), .in_ready(fetch_ready),
		.rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.fwd_ex(fwd_ex), .fwd_exm(fwd_exm), .fwd_mem(fwd_mem),
		.out_valid(dec_valid), .out(dec), .out_ready(dec_ready)
	);

	execute_unit i_execute_unit (
		.dec(dec), .dec_valid(dec_valid), .dec_ready(dec_ready), .fwd(fwd_ex),
		.out(exe_out), .out_valid(exe_valid), .out_ready(exe_ready)
	);

	pipe_reg #(.payload_t(rv_core_pkg::exm_t)) i_exm_reg (
		.clock(clock), .reset(reset),
		.in_valid(exe_valid), .in_ready(exe_ready), .din(exe_out),
		.out_valid(exm_valid), .dout(exm), .out_ready(exm_ready)
	);

	mem_stage i_mem_stage (
		.clock(clock), .reset(reset),
		.in_valid(exm_valid), .in_ready(exm_ready), .din(exm),
		.fwd_in(fwd_exm), .fwd(fwd_mem),
		.out_valid(mem_valid), .out(mem_out), .out_ready(mem_ready)
	);

	// The retire port never pushes back.
	pipe_reg #(.payload_t(rv_core_pkg::ret_t)) i_ret_reg (
		.clock(clock), .reset(reset),
		.in_valid(mem_valid), .in_ready(mem_ready), .din(mem_out),
		.out_valid(retire_valid), .dout(retire), .out_ready(1'b1)
	);

endmodule

// File: sim/rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
	input logic                               clock,
	input logic                               reset,
	input logic                               in_valid,
	input logic                               in_ready,
	input logic [31:0]                        inst,
	input logic [31:0]                        pc,
	input logic [rv_core_pkg::reg_addr_w-1:0] rs1,
	input logic [rv_core_pkg::reg_addr_w-1:0] rs2,
	input logic                               need_rs1,
	input logic                               need_rs2,
	input rv_core_pkg::fwd_t                  fwd_ex,
	input rv_core_pkg::fwd_t                  fwd_exm,
	input rv_core_pkg::fwd_t                  fwd_mem,
	input logic                               out_valid,
	input logic                               out_ready,
	input rv_core_pkg::dec_t                  out
);

	logic stall_needed;

	function automatic logic writes(
		input rv_core_pkg::fwd_t                 f,
		input logic [rv_core_pkg::reg_addr_w-1:0] r
	);
		return f.busy && f.reg_wen && (f.rd == r);
	endfunction

	// The youngest writer of r decides whether its value is still a load in flight.
	function automatic logic load_wait(
		input logic [rv_core_pkg::reg_addr_w-1:0] r,
		input rv_core_pkg::fwd_t                 ex,
		input rv_core_pkg::fwd_t                 exm,
		input rv_core_pkg::fwd_t                 mem
	);
		logic pending;
		pending = 1'b0;
		if (r != '0) begin
			if (writes(ex, r)) begin
				pending = ex.load_pending;
			end else if (writes(exm, r)) begin
				pending = exm.load_pending;
			end else if (writes(mem, r)) begin
				pending = mem.load_pending;
			end
		end
		return pending;
	endfunction

	assign stall_needed = (need_rs1 && load_wait(rs1, fwd_ex, fwd_exm, fwd_mem))
		|| (need_rs2 && load_wait(rs2, fwd_ex, fwd_exm, fwd_mem));

	// A stalled fetch keeps its word and pc.
	property fetch_stable;
		@(posedge clock) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(inst) && $stable(pc);
	endproperty

	property out_held;
		@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out);
	endproperty

	property hazard_stalls;
		@(posedge clock) disable iff (reset)
		stall_needed |-> !in_ready;
	endproperty

	assert property (fetch_stable) else $error("fetch input changed while stalled");
	assert property (out_held) else $error("decode output dropped or changed before ready");
	assert property (hazard_stalls) else $error("fetch accepted during a load-use hazard");

endmodule

bind decode_stage rv_core_asserts i_rv_core_asserts (
	.clock(clock), .reset(reset),
	.in_valid(in_valid), .in_ready(in_ready), .inst(inst), .pc(pc),
	.rs1(rs1), .rs2(rs2), .need_rs1(need_rs1), .need_rs2(need_rs2),
	.fwd_ex(fwd_ex), .fwd_exm(fwd_exm), .fwd_mem(fwd_mem),
	.out_valid(out_valid), .out_ready(out_ready), .out(out)
);

// File: sim/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

	localparam int num_entries    = 22;
	localparam int num_passes     = 2;
	localparam int timeout_cycles = 50;
	localparam int idle_cycles    = 10;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic [3:0]  rd;
		logic        reg_wen;
		logic [31:0] data;
	} entry_t;

	logic              clock;
	logic              reset;
	logic              fetch_valid;
	logic [31:0]       fetch_inst;
	logic [31:0]       fetch_pc;
	logic              fetch_ready;
	logic              retire_valid;
	rv_core_pkg::ret_t retire;

	entry_t stim [num_entries];
	integer seed;
	int     error_count;
	int     timeout_count;
	int     retired_count;

	rv_core_top i_rv_core_top (
		.clock(clock), .reset(reset),
		.fetch_valid(fetch_valid), .fetch_inst(fetch_inst), .fetch_pc(fetch_pc),
		.fetch_ready(fetch_ready), .retire_valid(retire_valid), .retire(retire)
	);

	always #5 clock = ~clock;

	// ====================================================================
	// Program and expected retire values.
	// ====================================================================
	task automatic build_table();
		// lui, auipc, addi, add, sub with forwarding.
		stim[0]  = '{32'h123450B7, 32'h00, 4'd1,  1'b1, 32'h12345000};
		stim[1]  = '{32'h00001117, 32'h04, 4'd2,  1'b1, 32'h00001004};
		stim[2]  = '{32'h67808193, 32'h08, 4'd3,  1'b1, 32'h12345678};
		stim[3]  = '{32'h00218233, 32'h0C, 4'd4,  1'b1, 32'h1234667C};
		stim[4]  = '{32'h401202B3, 32'h10, 4'd5,  1'b1, 32'h0000167C};
		stim[5]  = '{32'hFFF28313, 32'h14, 4'd6,  1'b1, 32'h0000167B};
		// Store, load back, then a load-use stall.
		stim[6]  = '{32'h00402823, 32'h18, 4'd0,  1'b0, 32'h00000000};
		stim[7]  = '{32'h01002383, 32'h1C, 4'd7,  1'b1, 32'h1234667C};
		stim[8]  = '{32'h00438413, 32'h20, 4'd8,  1'b1, 32'h12346680};
		// Links, beq and csr.
		stim[9]  = '{32'h008004EF, 32'h24, 4'd9,  1'b1, 32'h00000028};
		stim[10] = '{32'h00008567, 32'h28, 4'd10, 1'b1, 32'h0000002C};
		stim[11] = '{32'h00208463, 32'h2C, 4'd0,  1'b0, 32'h00000000};
		stim[12] = '{32'h300195F3, 32'h30, 4'd0,  1'b0, 32'h00000000};
		// Write to x0, then reads of x0.
		stim[13] = '{32'h00518013, 32'h34, 4'd0,  1'b1, 32'h1234567D};
		stim[14] = '{32'h00200633, 32'h38, 4'd12, 1'b1, 32'h00001004};
		stim[15] = '{32'h00160693, 32'h3C, 4'd13, 1'b1, 32'h00001005};
		stim[16] = '{32'h00C68733, 32'h40, 4'd14, 1'b1, 32'h00002009};
		stim[17] = '{32'h02E02423, 32'h44, 4'd0,  1'b0, 32'h00000000};
		stim[18] = '{32'h02802783, 32'h48, 4'd15, 1'b1, 32'h00002009};
		// Both operands wait on the load.
		stim[19] = '{32'h00F780B3, 32'h4C, 4'd1,  1'b1, 32'h00004012};
		stim[20] = '{32'h40408133, 32'h50, 4'd2,  1'b1, 32'hEDCBD996};
		stim[21] = '{32'h00700193, 32'h54, 4'd3,  1'b1, 32'h00000007};
	endtask

	task automatic apply_reset();
		reset       = 1'b1;
		fetch_valid = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	// ====================================================================
	// Fetch driver.
	// ====================================================================
	task automatic send_entry(input entry_t e, output logic accepted);
		logic seen;
		seen        = 1'b0;
		fetch_valid = 1'b1;
		fetch_inst  = e.inst;
		fetch_pc    = e.pc;
		for (int w = 0; w < timeout_cycles && !seen; w++) begin
			@(negedge clock);
			seen = fetch_ready;
		end
		@(posedge clock);
		#1;
		fetch_valid = 1'b0;
		accepted    = seen;
	endtask

	task automatic drive_pass(input int max_gap, output logic ok);
		int   gap;
		logic accepted;
		ok = 1'b1;
		for (int i = 0; i < num_entries && ok; i++) begin
			gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
			send_entry(stim[i], accepted);
			if (!accepted) begin
				$display("Timeout at %0t: fetch_ready stayed low for entry %0d", $time, i);
				timeout_count++;
				ok = 1'b0;
			end
		end
	endtask

	// ====================================================================
	// Retire checker.
	// ====================================================================
	task automatic check_retire(input int i);
		entry_t e;
		e = stim[i];
		retired_count++;
		assert (retire.pc == e.pc) else begin
			error_count++;
			$display("ERROR at %0t: entry %0d pc %h, expected %h", $time, i, retire.pc, e.pc);
		end
		assert (retire.reg_wen == e.reg_wen) else begin
			error_count++;
			$display("ERROR at %0t: entry %0d reg_wen %b, expected %b",
				$time, i, retire.reg_wen, e.reg_wen);
		end
		if (e.reg_wen) begin
			assert (retire.rd == e.rd) else begin
				error_count++;
				$display("ERROR at %0t: entry %0d rd %0d, expected %0d", $time, i, retire.rd, e.rd);
			end
			assert (retire.data == e.data) else begin
				error_count++;
				$display("ERROR at %0t: entry %0d data %h, expected %h",
					$time, i, retire.data, e.data);
			end
		end
	endtask

	task automatic check_pass(output logic ok);
		logic got;
		ok = 1'b1;
		for (int i = 0; i < num_entries && ok; i++) begin
			got = 1'b0;
			for (int w = 0; w < timeout_cycles && !got; w++) begin
				@(negedge clock);
				got = retire_valid;
			end
			if (got) begin
				check_retire(i);
			end else begin
				$display("Timeout at %0t: entry %0d never retired", $time, i);
				timeout_count++;
				ok = 1'b0;
			end
		end
	endtask

	// Nothing may retire once the table is drained.
	task automatic check_idle();
		repeat (idle_cycles) begin
			@(negedge clock);
			assert (!retire_valid) else begin
				error_count++;
				$display("ERROR at %0t: extra retire of pc %h", $time, retire.pc);
			end
		end
	endtask

	initial begin
		logic drive_ok;
		logic check_ok;
		clock         = 1'b0;
		reset         = 1'b1;
		fetch_valid   = 1'b0;
		fetch_inst    = '0;
		fetch_pc      = '0;
		seed          = 66296;
		error_count   = 0;
		timeout_count = 0;
		retired_count = 0;
		build_table();
		// First pass runs back to back, the second with random idle gaps.
		for (int p = 0; p < num_passes && timeout_count == 0; p++) begin
			if (p > 0) begin
				@(posedge clock);
				#1;
			end
			apply_reset();
			fork
				drive_pass((p == 0) ? 0 : 3, drive_ok);
				check_pass(check_ok);
			join
			if (check_ok && drive_ok) begin
				check_idle();
			end
		end
		$display("Errors: %0d, timeouts: %0d, retired: %0d of %0d",
			error_count, timeout_count, retired_count, num_passes * num_entries);
		if (error_count == 0 && timeout_count == 0
			&& retired_count == num_passes * num_entries) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: rv_core.f
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_unit.sv
verilog/pipe_reg.sv
verilog/mem_stage.sv
verilog/rv_core_top.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv

// File: Makefile
# Verilator build and run for rv_core.

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard verilog/*.sv sim/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
